/* hdl/dsp_cfg_pkg.sv */
`default_nettype none

package dsp_cfg_pkg;

	// pulse channels, one DAC output each
	localparam int n_ch = 2;

	// Q15 sample parts and accumulator parts
	localparam int sample_w = 16;
	localparam int acc_w = 32;

	// envelope table and pulse length
	localparam int env_addr_w = 8;
	localparam int len_w = 8;

	// programmed shot count
	localparam int shot_w = 16;

	// capture buffer depths, 64 and 8 entries
	localparam int acq_addr_w = 6;
	localparam int acc_addr_w = 3;

	// two multiplier stages plus the row adder
	localparam int xt_latency = 3;
	// two multiplier stages plus the accumulator register
	localparam int mac_latency = 3;

endpackage

`default_nettype wire

/* hdl/dsp_data_pkg.sv */
`default_nettype none

package dsp_data_pkg;

	// complex sample, real part in the upper half
	typedef struct packed {
		logic signed [dsp_cfg_pkg::sample_w-1:0] re;
		logic signed [dsp_cfg_pkg::sample_w-1:0] im;
	} cplx_t;

	// Q15 matrix or mixer coefficient
	typedef struct packed {
		logic signed [dsp_cfg_pkg::sample_w-1:0] re;
		logic signed [dsp_cfg_pkg::sample_w-1:0] im;
	} coef_t;

	// per-shot complex sum
	typedef struct packed {
		logic signed [dsp_cfg_pkg::acc_w-1:0] re;
		logic signed [dsp_cfg_pkg::acc_w-1:0] im;
	} acc_t;

	// shot loop states
	typedef enum logic [2:0] {
		st_idle,
		st_start,
		st_proc_run,
		st_elem_busy,
		st_more_shot,
		st_done
	} seq_state_t;

endpackage

`default_nettype wire

/* hdl/cmplx_mult.sv */
`timescale 1ns/1ns
`default_nettype none

module cmplx_mult (
	input wire dspif,
	input wire dsp_data_pkg::cplx_t a,
	input wire dsp_data_pkg::coef_t b,
	output dsp_data_pkg::cplx_t p
);
	import dsp_cfg_pkg::*;

	logic signed [2*sample_w-1:0] rr;
	logic signed [2*sample_w-1:0] ii;
	logic signed [2*sample_w-1:0] ri;
	logic signed [2*sample_w-1:0] ir;
	logic signed [2*sample_w:0] re_full;
	logic signed [2*sample_w:0] im_full;

	assign re_full = rr - ii;
	assign im_full = ri + ir;

	always_ff @(posedge dspif) begin
		// stage 1, partial products
		rr <= a.re * b.re;
		ii <= a.im * b.im;
		ri <= a.re * b.im;
		ir <= a.im * b.re;
		// stage 2, Q15 scaling keeps bits 30 to 15
		p.re <= re_full[2*sample_w-2:sample_w-1];
		p.im <= im_full[2*sample_w-2:sample_w-1];
	end

endmodule

`default_nettype wire

/* hdl/capture_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_writer #(
	parameter type payload_t = logic [31:0],
	parameter int addr_w = 6
) (
	input wire dspif,
	input wire rst,
	input wire clear,
	input wire stb,
	input wire payload_t data,
	output logic we,
	output logic [addr_w-1:0] addr,
	output payload_t wdata
);

	// address for the next write
	logic [addr_w-1:0] ptr;
	logic [addr_w-1:0] base;

	assign base = clear ? '0 : ptr;

	always_ff @(posedge dspif) begin
		if (rst) begin
			we <= 1'b0;
			addr <= '0;
			ptr <= '0;
		end else begin
			we <= stb;
			if (stb) begin
				addr <= base;
				// stick at the last entry once full
				ptr <= (&base) ? base : base + 1'b1;
			end else if (clear) begin
				ptr <= '0;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (stb) begin
			wdata <= data;
		end
	end

endmodule

`default_nettype wire

/* hdl/shot_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module shot_sequencer (
	input wire dspif,
	input wire rst,
	input wire stb_start,
	input wire [dsp_cfg_pkg::shot_w-1:0] nshot,
	input wire [dsp_cfg_pkg::n_ch-1:0] core_done,
	input wire [dsp_cfg_pkg::n_ch-1:0] core_idle,
	input wire mac_idle,
	output logic core_start,
	output logic [dsp_cfg_pkg::shot_w-1:0] shot_cnt,
	output logic last_shot_done,
	output dsp_data_pkg::seq_state_t state
);
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	seq_state_t next_state;
	logic [shot_w-1:0] nshot_q;
	logic [n_ch-1:0] done_seen;
	logic all_done;
	logic all_idle;
	logic last_shot;

	// a done strobe in this very cycle already counts
	assign all_done = &(done_seen | core_done);
	assign all_idle = (&core_idle) & mac_idle;
	assign last_shot = (shot_cnt == shot_w'(nshot_q - 1'b1));

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				next_state = stb_start ? st_start : st_idle;
			end
			st_start: begin
				next_state = st_proc_run;
			end
			st_proc_run: begin
				next_state = all_done ? st_elem_busy : st_proc_run;
			end
			// wait for the pipelines and the pending sum to drain
			st_elem_busy: begin
				next_state = all_idle ? st_more_shot : st_elem_busy;
			end
			st_more_shot: begin
				next_state = last_shot ? st_done : st_start;
			end
			st_done: begin
				next_state = st_idle;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge dspif) begin
		if (rst) begin
			state <= st_idle;
			core_start <= 1'b0;
			last_shot_done <= 1'b0;
			shot_cnt <= '0;
			nshot_q <= '0;
			done_seen <= '0;
		end else begin
			state <= next_state;
			// registered from the next state so they line up with it
			core_start <= (next_state == st_start);
			last_shot_done <= (next_state == st_done);
			if (state == st_idle && stb_start) begin
				nshot_q <= nshot;
				shot_cnt <= '0;
			end else if (state == st_more_shot) begin
				shot_cnt <= shot_cnt + 1'b1;
			end
			// sticky done bits, fresh for every shot
			if (state == st_start) begin
				done_seen <= '0;
			end else begin
				done_seen <= done_seen | core_done;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pulse_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_core (
	input wire dspif,
	input wire rst,
	input wire start,
	input wire [dsp_cfg_pkg::len_w-1:0] pulse_len,
	output logic [dsp_cfg_pkg::env_addr_w-1:0] env_addr,
	input wire dsp_data_pkg::cplx_t env_data,
	output dsp_data_pkg::cplx_t sample,
	output logic valid,
	output logic done,
	output logic idle
);
	import dsp_cfg_pkg::*;

	logic [len_w-1:0] cnt;
	logic active;
	logic last_addr;

	assign last_addr = active && (cnt == len_w'(pulse_len - 1'b1));

	// sample counter drives the table address directly
	assign env_addr = env_addr_w'(cnt);

	// table data arrives one cycle after its address
	assign sample = valid ? env_data : '0;

	always_ff @(posedge dspif) begin
		if (rst) begin
			cnt <= '0;
			active <= 1'b0;
			valid <= 1'b0;
			done <= 1'b0;
			idle <= 1'b1;
		end else begin
			// one stage to match the table read latency
			valid <= active;
			done <= last_addr;
			if (start) begin
				cnt <= '0;
				active <= 1'b1;
			end else if (last_addr) begin
				cnt <= '0;
				active <= 1'b0;
			end else if (active) begin
				cnt <= cnt + 1'b1;
			end
			// busy until the last sample has gone out
			if (start) begin
				idle <= 1'b0;
			end else if (done) begin
				idle <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/crosstalk_matrix.sv */
`timescale 1ns/1ns
`default_nettype none

module crosstalk_matrix (
	input wire dspif,
	input wire rst,
	input wire dsp_data_pkg::cplx_t x [dsp_cfg_pkg::n_ch],
	input wire x_valid,
	input wire dsp_data_pkg::coef_t coef [dsp_cfg_pkg::n_ch][dsp_cfg_pkg::n_ch],
	output dsp_data_pkg::cplx_t dac [dsp_cfg_pkg::n_ch],
	output logic dac_valid
);
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	cplx_t prod [n_ch][n_ch];
	logic signed [sample_w-1:0] sum_re [n_ch];
	logic signed [sample_w-1:0] sum_im [n_ch];
	logic [xt_latency-1:0] vld_sr;

	// one multiplier per matrix element, row m feeds DAC m
	for (genvar m = 0; m < n_ch; m++) begin : gen_row
		for (genvar n = 0; n < n_ch; n++) begin : gen_col
			cmplx_mult cmult_mn (
				.dspif(dspif),
				.a(x[n]),
				.b(coef[m][n]),
				.p(prod[m][n])
			);
		end
	end

	// row sums wrap at the sample width
	always_comb begin
		for (int m = 0; m < n_ch; m++) begin
			sum_re[m] = '0;
			sum_im[m] = '0;
			for (int n = 0; n < n_ch; n++) begin
				sum_re[m] = sum_re[m] + prod[m][n].re;
				sum_im[m] = sum_im[m] + prod[m][n].im;
			end
		end
	end

	always_ff @(posedge dspif) begin
		for (int m = 0; m < n_ch; m++) begin
			dac[m].re <= sum_re[m];
			dac[m].im <= sum_im[m];
		end
	end

	// valid follows the data through multiplier and adder
	always_ff @(posedge dspif) begin
		if (rst) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[xt_latency-2:0], x_valid};
		end
	end

	assign dac_valid = vld_sr[xt_latency-1];

endmodule

`default_nettype wire

/* hdl/mix_accumulate.sv */
`timescale 1ns/1ns
`default_nettype none

module mix_accumulate (
	input wire dspif,
	input wire rst,
	input wire dsp_data_pkg::cplx_t lo,
	input wire lo_valid,
	input wire lo_done,
	input wire dsp_data_pkg::cplx_t adc,
	output dsp_data_pkg::acc_t acc,
	output logic acc_stb,
	output logic idle
);
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	cplx_t prod;
	acc_t sum_q;
	acc_t sum_next;
	// valid and done delayed by the multiplier latency
	logic [mac_latency-2:0] vld_d;
	logic [mac_latency-2:0] done_d;

	cmplx_mult mix_mult (
		.dspif(dspif),
		.a(lo),
		.b(coef_t'(adc)),
		.p(prod)
	);

	// running sum with the product leaving the multiplier now
	always_comb begin
		sum_next = sum_q;
		if (vld_d[mac_latency-2]) begin
			sum_next.re = sum_q.re + prod.re;
			sum_next.im = sum_q.im + prod.im;
		end
	end

	always_ff @(posedge dspif) begin
		if (rst) begin
			vld_d <= '0;
			done_d <= '0;
			sum_q <= '0;
			acc_stb <= 1'b0;
			idle <= 1'b1;
		end else begin
			vld_d <= {vld_d[mac_latency-3:0], lo_valid};
			done_d <= {done_d[mac_latency-3:0], lo_done};
			acc_stb <= done_d[mac_latency-2];
			// restart from zero once the shot sum is out
			sum_q <= done_d[mac_latency-2] ? '0 : sum_next;
			if (lo_valid) begin
				idle <= 1'b0;
			end else if (done_d[mac_latency-2]) begin
				idle <= 1'b1;
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (done_d[mac_latency-2]) begin
			acc <= sum_next;
		end
	end

endmodule

`default_nettype wire

/* hdl/dsp_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dsp_top (
	input wire dspif,
	input wire rst,
	input wire stb_start,
	input wire [dsp_cfg_pkg::shot_w-1:0] nshot,
	input wire [dsp_cfg_pkg::len_w-1:0] pulse_len,
	input wire dsp_data_pkg::coef_t coef [dsp_cfg_pkg::n_ch][dsp_cfg_pkg::n_ch],
	output logic [dsp_cfg_pkg::env_addr_w-1:0] env_addr [dsp_cfg_pkg::n_ch],
	input wire dsp_data_pkg::cplx_t env_data [dsp_cfg_pkg::n_ch],
	input wire dsp_data_pkg::cplx_t adc,
	input wire clear_acq,
	input wire clear_acc,
	output dsp_data_pkg::cplx_t dac [dsp_cfg_pkg::n_ch],
	output logic dac_valid,
	output logic acc_we,
	output logic [dsp_cfg_pkg::acc_addr_w-1:0] acc_addr,
	output dsp_data_pkg::acc_t acc_data,
	output logic acq_we,
	output logic [dsp_cfg_pkg::acq_addr_w-1:0] acq_addr,
	output dsp_data_pkg::cplx_t acq_data,
	output logic [dsp_cfg_pkg::shot_w-1:0] shot_cnt,
	output logic last_shot_done
);
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	logic core_start;
	logic [n_ch-1:0] core_done;
	logic [n_ch-1:0] core_idle;
	logic [n_ch-1:0] core_valid;
	cplx_t core_sample [n_ch];
	seq_state_t seq_state;
	acc_t acc_sum;
	logic acc_stb;
	logic mac_idle;
	cplx_t adc_q;

	// ADC input register, shared by mixer and acquisition
	always_ff @(posedge dspif) begin
		adc_q <= adc;
	end

	shot_sequencer u_seq (
		.dspif(dspif),
		.rst(rst),
		.stb_start(stb_start),
		.nshot(nshot),
		.core_done(core_done),
		.core_idle(core_idle),
		.mac_idle(mac_idle),
		.core_start(core_start),
		.shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done),
		.state(seq_state)
	);

	for (genvar i = 0; i < n_ch; i++) begin : gen_core
		pulse_core u_core (
			.dspif(dspif),
			.rst(rst),
			.start(core_start),
			.pulse_len(pulse_len),
			.env_addr(env_addr[i]),
			.env_data(env_data[i]),
			.sample(core_sample[i]),
			.valid(core_valid[i]),
			.done(core_done[i]),
			.idle(core_idle[i])
		);
	end

	// cores start together, so their valids coincide
	crosstalk_matrix u_xt (
		.dspif(dspif),
		.rst(rst),
		.x(core_sample),
		.x_valid(&core_valid),
		.coef(coef),
		.dac(dac),
		.dac_valid(dac_valid)
	);

	// channel 0 doubles as the readout LO
	mix_accumulate u_mac (
		.dspif(dspif),
		.rst(rst),
		.lo(core_sample[0]),
		.lo_valid(core_valid[0]),
		.lo_done(core_done[0]),
		.adc(adc_q),
		.acc(acc_sum),
		.acc_stb(acc_stb),
		.idle(mac_idle)
	);

	capture_writer #(
		.payload_t(acc_t),
		.addr_w(acc_addr_w)
	) u_acc_wr (
		.dspif(dspif),
		.rst(rst),
		.clear(clear_acc),
		.stb(acc_stb),
		.data(acc_sum),
		.we(acc_we),
		.addr(acc_addr),
		.wdata(acc_data)
	);

	// raw ADC capture, one write per cycle
	capture_writer #(
		.payload_t(cplx_t),
		.addr_w(acq_addr_w)
	) u_acq_wr (
		.dspif(dspif),
		.rst(rst),
		.clear(clear_acq),
		.stb(1'b1),
		.data(adc_q),
		.we(acq_we),
		.addr(acq_addr),
		.wdata(acq_data)
	);

endmodule

`default_nettype wire

/* tests/dsp_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module dsp_sva (
	input wire dspif,
	input wire rst,
	input wire last_shot_done,
	input wire acc_stb,
	input wire acc_we,
	input wire clear_acq,
	input wire [dsp_cfg_pkg::shot_w-1:0] shot_cnt,
	input wire dsp_data_pkg::seq_state_t state,
	input wire [dsp_cfg_pkg::acc_addr_w-1:0] acc_addr,
	input wire [dsp_cfg_pkg::acq_addr_w-1:0] acq_addr
);
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	// number of failed assertions so far
	int fail_cnt = 0;

	// done state lasts a single cycle
	assert property (@(posedge dspif) disable iff (rst) last_shot_done |=> !last_shot_done)
	else begin
		fail_cnt++;
		$error("last_shot_done held for more than one cycle");
	end

	// writer registers the strobe
	assert property (@(posedge dspif) disable iff (rst) acc_we == $past(acc_stb))
	else begin
		fail_cnt++;
		$error("acc_we does not follow acc_stb by one cycle");
	end

	assert property (@(posedge dspif) disable iff (rst) state == st_idle |-> $stable(shot_cnt))
	else begin
		fail_cnt++;
		$error("shot_cnt changed while the sequencer was idle");
	end

	assert property (@(posedge dspif) disable iff (rst) !$isunknown(acc_addr))
	else begin
		fail_cnt++;
		$error("acc_addr unknown");
	end

	// acquisition address sticks at its maximum until cleared
	assert property (@(posedge dspif) disable iff (rst)
		(acq_addr == acq_addr_w'((1 << acq_addr_w) - 1)) && !clear_acq
		|=> acq_addr == acq_addr_w'((1 << acq_addr_w) - 1))
	else begin
		fail_cnt++;
		$error("acq_addr left its maximum without a clear");
	end

endmodule

bind dsp_top dsp_sva u_sva (
	.dspif(dspif),
	.rst(rst),
	.last_shot_done(last_shot_done),
	.acc_stb(acc_stb),
	.acc_we(acc_we),
	.clear_acq(clear_acq),
	.shot_cnt(shot_cnt),
	.state(seq_state),
	.acc_addr(acc_addr),
	.acq_addr(acq_addr)
);

`default_nettype wire

/* tests/dsp_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dsp_tb;
	import dsp_cfg_pkg::*;
	import dsp_data_pkg::*;

	// the tests take about 1900 cycles, twice that is the limit
	localparam int timeout_cycles = 4000;

	logic dspif;
	logic rst;
	logic stb_start;
	logic [shot_w-1:0] nshot;
	logic [len_w-1:0] pulse_len;
	coef_t coef [n_ch][n_ch];
	logic [env_addr_w-1:0] env_addr [n_ch];
	cplx_t env_data [n_ch];
	cplx_t adc;
	logic clear_acq;
	logic clear_acc;
	cplx_t dac [n_ch];
	logic dac_valid;
	logic acc_we;
	logic [acc_addr_w-1:0] acc_addr;
	acc_t acc_data;
	logic acq_we;
	logic [acq_addr_w-1:0] acq_addr;
	cplx_t acq_data;
	logic [shot_w-1:0] shot_cnt;
	logic last_shot_done;

	cplx_t env_tab [n_ch][256];
	cplx_t adc_mem [4096];
	logic [env_addr_w-1:0] addr_hold [n_ch];
	int cyc = 0;
	int exp_acc_addr = 0;

	dsp_top i_dut (
		.dspif(dspif),
		.rst(rst),
		.stb_start(stb_start),
		.nshot(nshot),
		.pulse_len(pulse_len),
		.coef(coef),
		.env_addr(env_addr),
		.env_data(env_data),
		.adc(adc),
		.clear_acq(clear_acq),
		.clear_acc(clear_acc),
		.dac(dac),
		.dac_valid(dac_valid),
		.acc_we(acc_we),
		.acc_addr(acc_addr),
		.acc_data(acc_data),
		.acq_we(acq_we),
		.acq_addr(acq_addr),
		.acq_data(acq_data),
		.shot_cnt(shot_cnt),
		.last_shot_done(last_shot_done)
	);

	initial begin
		dspif = 1'b0;
		forever #50 dspif = ~dspif;
	end

	// envelope ROMs return the data one cycle after the address
	always @(posedge dspif) begin
		cyc <= cyc + 1;
		#10;
		adc = adc_mem[cyc];
		for (int i = 0; i < n_ch; i++) begin
			env_data[i] = env_tab[i][addr_hold[i]];
		end
	end

	always @(negedge dspif) begin
		for (int i = 0; i < n_ch; i++) begin
			addr_hold[i] = env_addr[i];
		end
	end

	always @(posedge dspif) begin
		if (cyc >= timeout_cycles) begin
			abort_run($sformatf("timeout, the DUT did not finish within %0d cycles",
				timeout_cycles));
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_cplx(input cplx_t got, input cplx_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at %0t ns: %s got %h/%h expected %h/%h",
				$time, what, got.re, got.im, exp.re, exp.im));
		end
	endtask

	task automatic check_acc(input acc_t got, input acc_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at %0t ns: %s got %h/%h expected %h/%h",
				$time, what, got.re, got.im, exp.re, exp.im));
		end
	endtask

	task automatic check_count(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at %0t ns: %s got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	// Q15 product, bits 30 to 15 of each full part
	function automatic cplx_t mul_q15(input cplx_t a, input coef_t b);
		longint re_full;
		longint im_full;
		cplx_t r;
		re_full = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
		im_full = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
		r.re = re_full[30:15];
		r.im = im_full[30:15];
		return r;
	endfunction

	// DAC m for table entry k, sums wrap at 16 bits
	function automatic cplx_t xt_model(input int m, input int k);
		cplx_t r;
		cplx_t p;
		r = '0;
		for (int n = 0; n < n_ch; n++) begin
			p = mul_q15(env_tab[n][k], coef[m][n]);
			r.re = r.re + p.re;
			r.im = r.im + p.im;
		end
		return r;
	endfunction

	task automatic fill_tables(input bit nonpos);
		for (int i = 0; i < n_ch; i++) begin
			for (int a = 0; a < 256; a++) begin
				env_tab[i][a] = $urandom;
				if (nonpos) begin
					env_tab[i][a].re = -(16'($urandom % 32768));
					env_tab[i][a].im = -(16'($urandom % 32768));
				end
			end
		end
	endtask

	task automatic set_coef(input bit identity);
		for (int m = 0; m < n_ch; m++) begin
			for (int n = 0; n < n_ch; n++) begin
				coef[m][n] = $urandom;
				if (identity) begin
					// Q15 unity, exact for non-positive parts
					coef[m][n].re = (m == n) ? 16'h7fff : 16'h0000;
					coef[m][n].im = 16'h0000;
				end
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge dspif);
		#10;
	endtask

	task automatic clear_acc_buffer();
		clear_acc = 1'b1;
		next_cycle();
		clear_acc = 1'b0;
		exp_acc_addr = 0;
	endtask

	// start a run and check the DAC stream and the sums until last_shot_done
	task automatic run_shots(input int nshot_v, input int len_v, input bit poke_start,
			input bit pass_through);
		int n_dac;
		int n_acc;
		int k;
		int step;
		int sum_re;
		int sum_im;
		bit finished;
		cplx_t p;
		acc_t exp_acc;
		n_dac = 0;
		n_acc = 0;
		step = 0;
		sum_re = 0;
		sum_im = 0;
		finished = 1'b0;
		nshot = shot_w'(nshot_v);
		pulse_len = len_w'(len_v);
		stb_start = 1'b1;
		while (!finished) begin
			next_cycle();
			step++;
			// a second start in the middle of the run
			stb_start = poke_start && (step == 5);
			@(negedge dspif);
			if (dac_valid) begin
				k = n_dac % len_v;
				for (int m = 0; m < n_ch; m++) begin
					check_cplx(dac[m], xt_model(m, k), $sformatf("dac[%0d] #%0d", m, n_dac));
					if (pass_through) begin
						check_cplx(dac[m], env_tab[m][k], "dac identity pass-through");
					end
				end
				// mixer sees channel 0 against the registered ADC sample
				p = mul_q15(env_tab[0][k], coef_t'(adc_mem[cyc - 4]));
				sum_re += p.re;
				sum_im += p.im;
				n_dac++;
			end
			if (acc_we) begin
				exp_acc.re = sum_re;
				exp_acc.im = sum_im;
				check_count(acc_addr, exp_acc_addr, "acc_addr");
				check_acc(acc_data, exp_acc, $sformatf("acc_data shot %0d", n_acc));
				sum_re = 0;
				sum_im = 0;
				if (exp_acc_addr < (1 << acc_addr_w) - 1) begin
					exp_acc_addr++;
				end
				n_acc++;
			end
			finished = last_shot_done;
		end
		check_count(n_acc, nshot_v, "acc_we writes before last_shot_done");
		check_count(n_dac, nshot_v * len_v, "dac_valid samples");
		check_count(shot_cnt, nshot_v, "shot_cnt at the end of the run");
		next_cycle();
	endtask

	task automatic test_reset();
		repeat (3) @(posedge dspif);
		@(negedge dspif);
		check_count(dac_valid, 0, "dac_valid in reset");
		check_count(last_shot_done, 0, "last_shot_done in reset");
		check_count(acc_we, 0, "acc_we in reset");
		check_count(acq_we, 0, "acq_we in reset");
		check_count(acc_addr, 0, "acc_addr in reset");
		check_count(acq_addr, 0, "acq_addr in reset");
		check_count(shot_cnt, 0, "shot_cnt in reset");
		next_cycle();
		rst = 1'b0;
		// first edge out of reset registers the first acquisition write
		next_cycle();
		@(negedge dspif);
		check_count(acq_we, 1, "acq_we after reset");
		check_count(acq_addr, 0, "first acq_addr after reset");
		check_count(shot_cnt, 0, "shot_cnt after reset");
		check_count(dac_valid | acc_we | last_shot_done, 0, "controls after reset");
		next_cycle();
	endtask

	task automatic test_shot_loop();
		set_coef(1'b0);
		run_shots(3, 64, 1'b1, 1'b0);
		// the ignored start must not launch another run
		repeat (20) begin
			@(negedge dspif);
			check_count(last_shot_done, 0, "second last_shot_done pulse");
			check_count(dac_valid, 0, "dac_valid after the run");
			check_count(shot_cnt, 3, "shot_cnt after the run");
			next_cycle();
		end
	endtask

	task automatic test_crosstalk();
		set_coef(1'b0);
		run_shots(1, 100, 1'b0, 1'b0);
		fill_tables(1'b1);
		set_coef(1'b1);
		run_shots(1, 80, 1'b0, 1'b1);
		fill_tables(1'b0);
	endtask

	task automatic test_accumulation();
		set_coef(1'b0);
		clear_acc_buffer();
		run_shots(9, 120, 1'b0, 1'b0);
		check_count(acc_addr, 7, "acc_addr after nine shots");
		clear_acc_buffer();
		run_shots(1, 120, 1'b0, 1'b0);
		check_count(acc_addr, 0, "acc_addr after clear_acc");
	endtask

	task automatic test_acquisition();
		clear_acq = 1'b1;
		next_cycle();
		clear_acq = 1'b0;
		for (int k = 0; k < 70; k++) begin
			@(negedge dspif);
			check_count(acq_we, 1, "acq_we");
			check_count(acq_addr, (k < 63) ? k : 63, "acq_addr");
			check_cplx(acq_data, adc_mem[cyc - 2], "acq_data");
			next_cycle();
		end
		clear_acq = 1'b1;
		next_cycle();
		clear_acq = 1'b0;
		for (int k = 0; k < 2; k++) begin
			@(negedge dspif);
			check_count(acq_addr, k, "acq_addr after clear_acq");
			check_cplx(acq_data, adc_mem[cyc - 2], "acq_data after clear_acq");
			next_cycle();
		end
	endtask

	initial begin
		void'($urandom(49));
		rst = 1'b1;
		stb_start = 1'b0;
		nshot = 1;
		pulse_len = 2;
		clear_acq = 1'b0;
		clear_acc = 1'b0;
		adc = '0;
		for (int i = 0; i < n_ch; i++) begin
			env_data[i] = '0;
		end
		for (int a = 0; a < 4096; a++) begin
			adc_mem[a] = $urandom;
		end
		fill_tables(1'b0);
		set_coef(1'b0);

		test_reset();
		test_shot_loop();
		test_crosstalk();
		test_accumulation();
		test_acquisition();

		if (i_dut.u_sva.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run("the bound assertion checker reported failures");
		end
	end

endmodule

`default_nettype wire

/* build.f */
hdl/dsp_cfg_pkg.sv
hdl/dsp_data_pkg.sv
hdl/cmplx_mult.sv
hdl/capture_writer.sv
hdl/shot_sequencer.sv
hdl/pulse_core.sv
hdl/crosstalk_matrix.sv
hdl/mix_accumulate.sv
hdl/dsp_top.sv
tests/dsp_sva.sv
tests/dsp_tb.sv
